/* include/host_chan_defines.svh */
// Host channel bridge widths and depths
// Shared by the host-memory path and the MMIO path

`ifndef HOST_CHAN_DEFINES_SVH
`define HOST_CHAN_DEFINES_SVH

// Host memory line address and data widths
`define HC_ADDR_W 16
`define HC_DATA_W 32

// Read reorder buffer depth; the tag indexes one slot, so keep log2 of the depth
`define HC_ROB_DEPTH 8
`define HC_TAG_W 3

// MMIO request fields
`define MMIO_ADDR_W 8
`define MMIO_DATA_W 32
`define MMIO_TID_W 4
`define MMIO_MAX_RD 4

`endif

/* source/host_chan_pkg.sv */
// Host channel bridge types
// MMIO opcodes and the state of one read reorder slot

package host_chan_pkg;

    // Opcode carried with every host MMIO request
    typedef enum logic [0:0] {
        MMIO_OP_RD = 1'b0,
        MMIO_OP_WR = 1'b1
    } t_mmio_op;

    // Life cycle of one read slot in the reorder buffer
    // A slot goes FREE -> WAIT on allocation, WAIT -> DONE when the host
    // answers its tag, and DONE -> FREE when it is released in order
    typedef enum logic [1:0] {
        SLOT_FREE = 2'd0,
        SLOT_WAIT = 2'd1,
        SLOT_DONE = 2'd2
    } t_slot_state;

endpackage

/* source/rd_rob_if.sv */
// Link between the host-memory mapper and the read reorder buffer
// Carries tag allocation and the in-order release of read data

`timescale 1ns/1ps
`include "host_chan_defines.svh"

interface rd_rob_if;

    // Mapper consumes the tail slot for one accepted read
    logic alloc;

    // Tag the next read will carry to the host
    logic [`HC_TAG_W-1:0] alloc_tag;

    // Every slot is in use, so no new read may be accepted
    logic rob_full;

    // Oldest outstanding read, released once its data has arrived
    logic out_valid;
    logic [`HC_DATA_W-1:0] out_data;

    // Mapper side issues reads and consumes sorted data
    modport mapper (
        output alloc,
        input  alloc_tag,
        input  rob_full,
        input  out_valid,
        input  out_data
    );

    // Buffer side hands out tags and releases data in issue order
    modport rob (
        input  alloc,
        output alloc_tag,
        output rob_full,
        output out_valid,
        output out_data
    );

endinterface

/* source/host_rd_rob.sv */
// Read reorder buffer for the host read channel
// Hands out tags in issue order and releases out-of-order responses in order

`timescale 1ns/1ps
`include "host_chan_defines.svh"

module host_rd_rob (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  c0_rsp_valid,
    input  logic [`HC_TAG_W-1:0]  c0_rsp_tag,
    input  logic [`HC_DATA_W-1:0] c0_rsp_data,
    rd_rob_if.rob                 rob
);

    // Per-slot state and the data returned for that slot
    host_chan_pkg::t_slot_state slot_state [`HC_ROB_DEPTH];
    logic [`HC_DATA_W-1:0]      slot_data [`HC_ROB_DEPTH];

    // Head is the oldest outstanding read, tail the next tag to hand out
    // Both wrap naturally because the depth is a power of two
    logic [`HC_TAG_W-1:0] head;
    logic [`HC_TAG_W-1:0] tail;

    // Head slot has its data and leaves this cycle
    logic release_head;

    // The next tag is always the tail slot
    assign rob.alloc_tag = tail;

    // When the tail slot is still in use the buffer has wrapped onto the head,
    // which means every slot holds an outstanding or unreleased read
    assign rob.rob_full = (slot_state[tail] != host_chan_pkg::SLOT_FREE);

    // A response stored in cycle t shows DONE in t+1 and is released right away
    assign release_head  = (slot_state[head] == host_chan_pkg::SLOT_DONE);
    assign rob.out_valid = release_head;
    assign rob.out_data  = slot_data[head];

    // Slot state and pointers
    // Allocation, response and release always hit different slots: the tail
    // is FREE, a responding slot is WAIT and the released head is DONE
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < `HC_ROB_DEPTH; i++) begin
                slot_state[i] <= host_chan_pkg::SLOT_FREE;
            end
        end else begin
            // Reserve the tail slot for a read just sent to the host
            if (rob.alloc) begin
                slot_state[tail] <= host_chan_pkg::SLOT_WAIT;
                tail             <= tail + 1'b1;
            end

            // The host answers tags in any order
            if (c0_rsp_valid) begin
                slot_state[c0_rsp_tag] <= host_chan_pkg::SLOT_DONE;
            end

            // One in-order release per cycle frees the head slot
            if (release_head) begin
                slot_state[head] <= host_chan_pkg::SLOT_FREE;
                head             <= head + 1'b1;
            end
        end
    end

    // Response payload lands in the slot named by its tag
    always_ff @(posedge clk) begin
        if (c0_rsp_valid) begin
            slot_data[c0_rsp_tag] <= c0_rsp_data;
        end
    end

endmodule

/* source/host_mem_avalon_map.sv */
// Host memory as an Avalon master port for the accelerator
// Avalon reads become tagged c0 requests, writes become c1 requests

`timescale 1ns/1ps
`include "host_chan_defines.svh"

module host_mem_avalon_map (
    input  logic                  clk,
    input  logic                  arst_n,

    // Accelerator host-memory master
    input  logic                  hm_read,
    input  logic                  hm_write,
    input  logic [`HC_ADDR_W-1:0] hm_address,
    input  logic [`HC_DATA_W-1:0] hm_writedata,
    output logic                  hm_waitrequest,
    output logic [`HC_DATA_W-1:0] hm_readdata,
    output logic                  hm_readdatavalid,
    output logic                  hm_writeresponsevalid,

    // Host read request channel
    output logic                  c0_req_valid,
    output logic [`HC_ADDR_W-1:0] c0_req_addr,
    output logic [`HC_TAG_W-1:0]  c0_req_tag,
    input  logic                  c0_almost_full,

    // Host write request channel and its in-order acknowledgement
    output logic                  c1_req_valid,
    output logic [`HC_ADDR_W-1:0] c1_req_addr,
    output logic [`HC_DATA_W-1:0] c1_req_data,
    input  logic                  c1_almost_full,
    input  logic                  c1_rsp_valid,

    rd_rob_if.mapper              rob
);

    // Low in reset and for its first cycle out, so the master is held off
    logic run_q;

    // Back-pressure per request kind
    logic rd_stall;
    logic wr_stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Reads also stop when every reorder slot is in use, since read data
    // cannot be refused on the Avalon side
    assign rd_stall = c0_almost_full | rob.rob_full;
    assign wr_stall = c1_almost_full;

    assign hm_waitrequest = ~run_q | (hm_read & rd_stall) | (hm_write & wr_stall);

    // An accepted command goes to the host in the same cycle
    assign c0_req_valid = hm_read & ~hm_waitrequest;
    assign c0_req_addr  = hm_address;
    assign c0_req_tag   = rob.alloc_tag;
    assign rob.alloc    = c0_req_valid;

    assign c1_req_valid = hm_write & ~hm_waitrequest;
    assign c1_req_addr  = hm_address;
    assign c1_req_data  = hm_writedata;

    // Sorted read data is already aligned to the issue order
    assign hm_readdatavalid = rob.out_valid;
    assign hm_readdata      = rob.out_data;

    // Writes are acknowledged in order by the host, one cycle later here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hm_writeresponsevalid <= 1'b0;
        end else begin
            hm_writeresponsevalid <= c1_rsp_valid;
        end
    end

endmodule

/* source/mmio_avalon_map.sv */
// Host MMIO requests as an Avalon slave port inside the accelerator
// One command register stage and a tid FIFO to pair read responses

`timescale 1ns/1ps
`include "host_chan_defines.svh"

module mmio_avalon_map (
    input  logic                     clk,
    input  logic                     arst_n,

    // Host MMIO request, one cycle per request
    input  logic                     mmio_req_valid,
    input  host_chan_pkg::t_mmio_op  mmio_req_op,
    input  logic [`MMIO_ADDR_W-1:0]  mmio_req_addr,
    input  logic [`MMIO_TID_W-1:0]   mmio_req_tid,
    input  logic [`MMIO_DATA_W-1:0]  mmio_req_data,

    // Host MMIO read response
    output logic                     mmio_rsp_valid,
    output logic [`MMIO_TID_W-1:0]   mmio_rsp_tid,
    output logic [`MMIO_DATA_W-1:0]  mmio_rsp_data,

    // Accelerator MMIO slave
    output logic                     mm_read,
    output logic                     mm_write,
    output logic [`MMIO_ADDR_W-1:0]  mm_address,
    output logic [`MMIO_DATA_W-1:0]  mm_writedata,
    input  logic                     mm_waitrequest,
    input  logic [`MMIO_DATA_W-1:0]  mm_readdata,
    input  logic                     mm_readdatavalid
);

    localparam int PTR_W = $clog2(`MMIO_MAX_RD);

    // Command stage
    logic                    cmd_valid_q;
    host_chan_pkg::t_mmio_op cmd_op_q;

    // Tids of reads waiting for data, oldest at rd_ptr
    logic [`MMIO_TID_W-1:0] tid_fifo [`MMIO_MAX_RD];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;

    logic push_tid;

    assign push_tid = mmio_req_valid & (mmio_req_op == host_chan_pkg::MMIO_OP_RD);

    // A new request loads the stage; it stays until the slave drops waitrequest
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid_q <= 1'b0;
        end else if (mmio_req_valid) begin
            cmd_valid_q <= 1'b1;
        end else if (!mm_waitrequest) begin
            cmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mmio_req_valid) begin
            cmd_op_q     <= mmio_req_op;
            mm_address   <= mmio_req_addr;
            mm_writedata <= mmio_req_data;
        end
    end

    assign mm_read  = cmd_valid_q & (cmd_op_q == host_chan_pkg::MMIO_OP_RD);
    assign mm_write = cmd_valid_q & (cmd_op_q == host_chan_pkg::MMIO_OP_WR);

    // FIFO pointers; the host never exceeds MMIO_MAX_RD reads in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_tid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mm_readdatavalid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_tid) begin
            tid_fifo[wr_ptr] <= mmio_req_tid;
        end
    end

    // Avalon returns read data in command order, so the oldest tid matches
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mmio_rsp_valid <= 1'b0;
        end else begin
            mmio_rsp_valid <= mm_readdatavalid;
        end
    end

    always_ff @(posedge clk) begin
        if (mm_readdatavalid) begin
            mmio_rsp_tid  <= tid_fifo[rd_ptr];
            mmio_rsp_data <= mm_readdata;
        end
    end

endmodule

/* source/host_chan_as_avalon.sv */
// Host channel to Avalon bridge top level
// Host memory master path through the read sorter, plus the MMIO slave path

`timescale 1ns/1ps
`include "host_chan_defines.svh"

module host_chan_as_avalon (
    input  logic                     clk,
    input  logic                     arst_n,

    // Host read channel
    output logic                     c0_req_valid,
    output logic [`HC_ADDR_W-1:0]    c0_req_addr,
    output logic [`HC_TAG_W-1:0]     c0_req_tag,
    input  logic                     c0_almost_full,
    input  logic                     c0_rsp_valid,
    input  logic [`HC_TAG_W-1:0]     c0_rsp_tag,
    input  logic [`HC_DATA_W-1:0]    c0_rsp_data,

    // Host write channel
    output logic                     c1_req_valid,
    output logic [`HC_ADDR_W-1:0]    c1_req_addr,
    output logic [`HC_DATA_W-1:0]    c1_req_data,
    input  logic                     c1_almost_full,
    input  logic                     c1_rsp_valid,

    // Host MMIO
    input  logic                     mmio_req_valid,
    input  host_chan_pkg::t_mmio_op  mmio_req_op,
    input  logic [`MMIO_ADDR_W-1:0]  mmio_req_addr,
    input  logic [`MMIO_TID_W-1:0]   mmio_req_tid,
    input  logic [`MMIO_DATA_W-1:0]  mmio_req_data,
    output logic                     mmio_rsp_valid,
    output logic [`MMIO_TID_W-1:0]   mmio_rsp_tid,
    output logic [`MMIO_DATA_W-1:0]  mmio_rsp_data,

    // Accelerator host-memory master
    input  logic                     hm_read,
    input  logic                     hm_write,
    input  logic [`HC_ADDR_W-1:0]    hm_address,
    input  logic [`HC_DATA_W-1:0]    hm_writedata,
    output logic                     hm_waitrequest,
    output logic [`HC_DATA_W-1:0]    hm_readdata,
    output logic                     hm_readdatavalid,
    output logic                     hm_writeresponsevalid,

    // Accelerator MMIO slave
    output logic                     mm_read,
    output logic                     mm_write,
    output logic [`MMIO_ADDR_W-1:0]  mm_address,
    output logic [`MMIO_DATA_W-1:0]  mm_writedata,
    input  logic                     mm_waitrequest,
    input  logic [`MMIO_DATA_W-1:0]  mm_readdata,
    input  logic                     mm_readdatavalid
);

    // Tag allocation and sorted data between the mapper and the sorter
    rd_rob_if rob_if ();

    // Puts host read responses back into issue order
    host_rd_rob rob_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .c0_rsp_valid (c0_rsp_valid),
        .c0_rsp_tag   (c0_rsp_tag),
        .c0_rsp_data  (c0_rsp_data),
        .rob          (rob_if.rob)
    );

    // Avalon host-memory master onto the c0 and c1 channels
    host_mem_avalon_map hm_map_i (
        .clk                   (clk),
        .arst_n                (arst_n),
        .hm_read               (hm_read),
        .hm_write              (hm_write),
        .hm_address            (hm_address),
        .hm_writedata          (hm_writedata),
        .hm_waitrequest        (hm_waitrequest),
        .hm_readdata           (hm_readdata),
        .hm_readdatavalid      (hm_readdatavalid),
        .hm_writeresponsevalid (hm_writeresponsevalid),
        .c0_req_valid          (c0_req_valid),
        .c0_req_addr           (c0_req_addr),
        .c0_req_tag            (c0_req_tag),
        .c0_almost_full        (c0_almost_full),
        .c1_req_valid          (c1_req_valid),
        .c1_req_addr           (c1_req_addr),
        .c1_req_data           (c1_req_data),
        .c1_almost_full        (c1_almost_full),
        .c1_rsp_valid          (c1_rsp_valid),
        .rob                   (rob_if.mapper)
    );

    // Host MMIO onto the accelerator slave, behind one register stage
    mmio_avalon_map mmio_map_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .mmio_req_valid   (mmio_req_valid),
        .mmio_req_op      (mmio_req_op),
        .mmio_req_addr    (mmio_req_addr),
        .mmio_req_tid     (mmio_req_tid),
        .mmio_req_data    (mmio_req_data),
        .mmio_rsp_valid   (mmio_rsp_valid),
        .mmio_rsp_tid     (mmio_rsp_tid),
        .mmio_rsp_data    (mmio_rsp_data),
        .mm_read          (mm_read),
        .mm_write         (mm_write),
        .mm_address       (mm_address),
        .mm_writedata     (mm_writedata),
        .mm_waitrequest   (mm_waitrequest),
        .mm_readdata      (mm_readdata),
        .mm_readdatavalid (mm_readdatavalid)
    );

endmodule

/* verif/host_chan_assert.sv */
// Protocol assertions for the host channel bridge
// Bound into the top level and counts its failed checks

`timescale 1ns/1ps
`include "host_chan_defines.svh"

module host_chan_assert (
    input logic clk,
    input logic arst_n,
    input logic c0_req_valid,
    input logic hm_read,
    input logic hm_readdatavalid,
    input logic mm_read,
    input logic mm_write
);

    // Reads sent to the host and not yet returned to the accelerator
    logic [`HC_TAG_W:0] outstanding;

    // Number of assertion failures so far
    int fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + (`HC_TAG_W+1)'(c0_req_valid)
                           - (`HC_TAG_W+1)'(hm_readdatavalid);
        end
    end

    // A host read needs an Avalon read and a free sorter slot
    c0_needs_read: assert property (@(posedge clk) disable iff (!arst_n)
        c0_req_valid |-> hm_read && (outstanding < `HC_ROB_DEPTH))
        else begin
            fail_count++;
            $error("c0 request without an Avalon read or with every slot in use");
        end

    rdv_needs_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        hm_readdatavalid |-> (outstanding != 0))
        else begin
            fail_count++;
            $error("read data with no read outstanding");
        end

    mm_one_command: assert property (@(posedge clk) disable iff (!arst_n)
        !(mm_read && mm_write))
        else begin
            fail_count++;
            $error("MMIO read and write together");
        end

endmodule

bind host_chan_as_avalon host_chan_assert assert_i (.*);

/* verif/host_chan_tb.sv */
// Testbench for the host channel bridge
// Host model answers reads out of order, accelerator model holds MMIO registers

`timescale 1ns/1ps
`include "host_chan_defines.svh"

module host_chan_tb;

    localparam int N_OPS = 24;
    localparam int K_HRD = 0;
    localparam int K_HWR = 1;
    localparam int K_MRD = 2;
    localparam int K_MWR = 3;
    localparam int TMO = 2000;

    logic clk;
    logic arst_n;
    logic c0_req_valid, c0_almost_full, c0_rsp_valid;
    logic [`HC_ADDR_W-1:0] c0_req_addr;
    logic [`HC_TAG_W-1:0] c0_req_tag, c0_rsp_tag;
    logic [`HC_DATA_W-1:0] c0_rsp_data;
    logic c1_req_valid, c1_almost_full, c1_rsp_valid;
    logic [`HC_ADDR_W-1:0] c1_req_addr;
    logic [`HC_DATA_W-1:0] c1_req_data;
    logic mmio_req_valid, mmio_rsp_valid;
    host_chan_pkg::t_mmio_op mmio_req_op;
    logic [`MMIO_ADDR_W-1:0] mmio_req_addr;
    logic [`MMIO_TID_W-1:0] mmio_req_tid, mmio_rsp_tid;
    logic [`MMIO_DATA_W-1:0] mmio_req_data, mmio_rsp_data;
    logic hm_read, hm_write, hm_waitrequest, hm_readdatavalid, hm_writeresponsevalid;
    logic [`HC_ADDR_W-1:0] hm_address;
    logic [`HC_DATA_W-1:0] hm_writedata, hm_readdata;
    logic mm_read, mm_write, mm_waitrequest, mm_readdatavalid;
    logic [`MMIO_ADDR_W-1:0] mm_address;
    logic [`MMIO_DATA_W-1:0] mm_writedata, mm_readdata;

    // Stimulus table of kind, address and write data
    int tbl_kind [N_OPS] = '{K_HWR, K_HRD, K_HRD, K_HRD, K_HRD, K_HRD, K_HRD, K_HRD,
                             K_HRD, K_HRD, K_HRD, K_HWR, K_HRD, K_MWR, K_MRD, K_MWR,
                             K_MRD, K_MRD, K_MRD, K_MRD, K_HWR, K_HRD, K_HRD, K_MRD};
    logic [15:0] tbl_addr [N_OPS] = '{16'h0010, 16'h0010, 16'h0003, 16'h0004, 16'h0005,
                                      16'h0006, 16'h0007, 16'h0008, 16'h0009, 16'h000a,
                                      16'h000b, 16'h0004, 16'h0004, 16'h0020, 16'h0020,
                                      16'h0021, 16'h0021, 16'h0020, 16'h0022, 16'h0021,
                                      16'h0100, 16'h0100, 16'h00ff, 16'h0023};
    logic [31:0] tbl_data [N_OPS] = '{32'hcafe0010, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                                      32'h12345678, 0, 32'ha5a50020, 0, 32'h5a5a0021,
                                      0, 0, 0, 0, 32'h0badf00d, 0, 0, 0};

    // Expected contents, kept apart from the models
    logic [31:0] exp_mem [65536];
    logic [31:0] exp_regs [256];
    logic [31:0] host_mem [65536];
    logic [31:0] acc_regs [256];
    logic [31:0] rd_exp [$];
    logic [35:0] mmio_exp [$];
    int rd_inflight = 0;
    int writes_issued = 0;
    int write_acks = 0;
    int mm_accepts = 0;

    host_chan_as_avalon dut_i (.*);

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act,
                               input string msg);
        if (exp !== act) begin
            $display("FAIL %0t: %s, expected %h got %h", $time, msg, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("TEST FAIL");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Host model with random almost-full and reads answered in random tag order
    // Read data is taken from host memory when the request arrives
    initial begin : host_model
        logic [34:0] pend [$];
        logic [34:0] ent;
        int idx;
        int wr_pend;
        bit filled;
        wr_pend = 0;
        filled = 1'b0;
        c0_almost_full = 1'b0;
        c1_almost_full = 1'b0;
        c0_rsp_valid = 1'b0;
        c0_rsp_tag = '0;
        c0_rsp_data = '0;
        c1_rsp_valid = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            host_mem[i] = 32'(i) + 32'h1000_0000;
        end
        forever begin
            @(negedge clk);
            if (c0_req_valid) begin
                pend.push_back({c0_req_tag, host_mem[c0_req_addr]});
            end
            if (c1_req_valid) begin
                host_mem[c1_req_addr] = c1_req_data;
                wr_pend++;
            end
            @(posedge clk);
            c0_almost_full <= ($urandom_range(3) == 0);
            c1_almost_full <= ($urandom_range(3) == 0);
            c0_rsp_valid <= 1'b0;
            // No read is answered until every sorter slot has been in use once
            if (pend.size() == `HC_ROB_DEPTH) begin
                filled = 1'b1;
            end
            if (filled && pend.size() > 0 && $urandom_range(2) == 0) begin
                idx = $urandom_range(pend.size() - 1);
                ent = pend[idx];
                pend.delete(idx);
                c0_rsp_valid <= 1'b1;
                c0_rsp_tag <= ent[34:32];
                c0_rsp_data <= ent[31:0];
            end
            c1_rsp_valid <= 1'b0;
            if (wr_pend > 0 && $urandom_range(1) == 0) begin
                c1_rsp_valid <= 1'b1;
                wr_pend--;
            end
        end
    end

    // Accelerator MMIO model with random waitrequest and read latency
    initial begin : acc_model
        logic [31:0] rdq [$];
        logic cmd_rd, cmd_wr, stall;
        logic [7:0] addr;
        logic [31:0] wdata;
        mm_waitrequest = 1'b1;
        mm_readdata = '0;
        mm_readdatavalid = 1'b0;
        for (int i = 0; i < 256; i++) begin
            acc_regs[i] = 32'h4d00_0000 + 32'(i * 7);
        end
        forever begin
            @(negedge clk);
            cmd_rd = mm_read;
            cmd_wr = mm_write;
            stall = mm_waitrequest;
            addr = mm_address;
            wdata = mm_writedata;
            @(posedge clk);
            if ((cmd_rd || cmd_wr) && !stall) begin
                mm_accepts++;
                if (cmd_wr) begin
                    acc_regs[addr] = wdata;
                end else begin
                    rdq.push_back(acc_regs[addr]);
                end
            end
            mm_waitrequest <= ($urandom_range(1) == 0);
            mm_readdatavalid <= 1'b0;
            if (rdq.size() > 0 && $urandom_range(2) == 0) begin
                mm_readdatavalid <= 1'b1;
                mm_readdata <= rdq.pop_front();
            end
        end
    end

    // Response and flow-control checks at the falling edge, where outputs are stable
    always @(negedge clk) begin
        if (arst_n) begin
            if (dut_i.assert_i.fail_count != 0) begin
                $display("TEST FAIL");
                $fatal(1, "protocol assertion failed");
            end
            if (c0_almost_full || rd_inflight == `HC_ROB_DEPTH) begin
                check_value(0, {31'b0, c0_req_valid}, "c0 request while stalled");
            end
            if (hm_read && (c0_almost_full || rd_inflight == `HC_ROB_DEPTH)) begin
                check_value(1, {31'b0, hm_waitrequest}, "waitrequest during read stall");
            end
            if (c1_almost_full) begin
                check_value(0, {31'b0, c1_req_valid}, "c1 request while almost full");
            end
            if (c0_req_valid) begin
                rd_inflight++;
            end
            if (hm_readdatavalid) begin
                check_value(1, {31'b0, rd_exp.size() > 0}, "unexpected read data");
                check_value(rd_exp.pop_front(), hm_readdata, "host read data");
                rd_inflight--;
            end
            if (hm_writeresponsevalid) begin
                write_acks++;
            end
            if (mmio_rsp_valid) begin
                check_value(1, {31'b0, mmio_exp.size() > 0}, "unexpected MMIO response");
                check_value({28'b0, mmio_exp[0][35:32]}, {28'b0, mmio_rsp_tid}, "MMIO tid");
                check_value(mmio_exp[0][31:0], mmio_rsp_data, "MMIO data");
                mmio_exp.delete(0);
            end
        end
    end

    task automatic host_op(input bit is_wr, input logic [15:0] addr, input logic [31:0] data);
        int t;
        @(posedge clk);
        hm_read <= !is_wr;
        hm_write <= is_wr;
        hm_address <= addr;
        hm_writedata <= data;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TMO) timed_out("host-memory command accept");
        end while (hm_waitrequest);
        if (is_wr) begin
            exp_mem[addr] = data;
            writes_issued++;
        end else begin
            rd_exp.push_back(exp_mem[addr]);
        end
        @(posedge clk);
        hm_read <= 1'b0;
        hm_write <= 1'b0;
    endtask

    task automatic mmio_op(input bit is_wr, input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] tid);
        int t;
        int start;
        t = 0;
        while (!is_wr && mmio_exp.size() >= `MMIO_MAX_RD) begin
            @(negedge clk);
            t++;
            if (t > TMO) timed_out("MMIO read slot");
        end
        start = mm_accepts;
        @(posedge clk);
        mmio_req_valid <= 1'b1;
        mmio_req_op <= is_wr ? host_chan_pkg::MMIO_OP_WR : host_chan_pkg::MMIO_OP_RD;
        mmio_req_addr <= addr;
        mmio_req_tid <= tid;
        mmio_req_data <= data;
        if (is_wr) begin
            exp_regs[addr] = data;
        end else begin
            mmio_exp.push_back({tid, exp_regs[addr]});
        end
        @(posedge clk);
        mmio_req_valid <= 1'b0;
        t = 0;
        while (mm_accepts == start) begin
            @(negedge clk);
            t++;
            if (t > TMO) timed_out("MMIO command accept");
        end
    endtask

    initial begin : main
        int t;
        logic [3:0] tid;
        tid = '0;
        void'($urandom(48));
        arst_n = 1'b0;
        hm_read = 1'b0;
        hm_write = 1'b0;
        hm_address = '0;
        hm_writedata = '0;
        mmio_req_valid = 1'b0;
        mmio_req_op = host_chan_pkg::MMIO_OP_RD;
        mmio_req_addr = '0;
        mmio_req_tid = '0;
        mmio_req_data = '0;
        for (int i = 0; i < 65536; i++) begin
            exp_mem[i] = 32'(i) + 32'h1000_0000;
        end
        for (int i = 0; i < 256; i++) begin
            exp_regs[i] = 32'h4d00_0000 + 32'(i * 7);
        end
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_value(0, {25'b0, c0_req_valid, c1_req_valid, hm_readdatavalid,
                    hm_writeresponsevalid, mm_read, mm_write, mmio_rsp_valid},
                    "control outputs in reset");
        check_value(1, {31'b0, hm_waitrequest}, "waitrequest in reset");
        @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < N_OPS; i++) begin
            case (tbl_kind[i])
                K_HRD: host_op(1'b0, tbl_addr[i], tbl_data[i]);
                K_HWR: host_op(1'b1, tbl_addr[i], tbl_data[i]);
                K_MRD: mmio_op(1'b0, tbl_addr[i][7:0], tbl_data[i], tid);
                default: mmio_op(1'b1, tbl_addr[i][7:0], tbl_data[i], tid);
            endcase
            tid = tid + 4'd1;
        end
        t = 0;
        while (rd_exp.size() > 0 || mmio_exp.size() > 0 || write_acks != writes_issued) begin
            @(negedge clk);
            t++;
            if (t > TMO) timed_out("outstanding responses to drain");
        end
        repeat (4) @(negedge clk);
        if (write_acks == writes_issued) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "extra write responses seen");
        end
    end

endmodule

/* list.f */
+incdir+include
source/host_chan_pkg.sv
source/rd_rob_if.sv
source/host_rd_rob.sv
source/host_mem_avalon_map.sv
source/mmio_avalon_map.sv
source/host_chan_as_avalon.sv
verif/host_chan_assert.sv
verif/host_chan_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= host_chan_tb
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
